// File: source/nabp_pkg.sv
package nabp_pkg;

    // projection line geometry
    localparam int k_line_size = 16;
    localparam int k_data_length = 12;
    localparam int k_filtered_data_length = 16;

    // one spare bit so an index can hold k_line_size itself
    localparam int k_s_length = $clog2(k_line_size + 1);
    // memory address bits, line end excluded
    localparam int k_addr_length = $clog2(k_line_size);

    // ramp kernel spans k_filter_order + 1 samples
    localparam int k_filter_order = 2;

    // half kernel plus host read plus filter output register
    localparam int k_delay_cycles = k_filter_order / 2 + 2;

    typedef logic signed [k_s_length-1:0] s_val_t;
    typedef logic signed [k_data_length-1:0] data_t;
    typedef logic signed [k_filtered_data_length-1:0] filtered_t;

    typedef enum logic [1:0] {
        ready_s,
        delay_s,
        fill_s
    } fill_state_t;

endpackage

// File: source/ramp_filter.sv
module ramp_filter
(
    input  logic                clk,
    input  logic                reset_n,
    input  nabp_pkg::data_t     hs_val,
    input  logic                sample_valid,
    output nabp_pkg::filtered_t filtered_val
);

    // newest tap, zero outside the line pads both edges
    nabp_pkg::data_t in_sample;

    // window[0] is the centre tap, higher entries are older
    nabp_pkg::data_t window [nabp_pkg::k_filter_order];

    // two guard bits above the filtered width
    logic signed [nabp_pkg::k_filtered_data_length+1:0] kernel_sum;

    assign in_sample = sample_valid ? hs_val : '0;

    // sample window shifts every cycle
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            for (int i = 0; i < nabp_pkg::k_filter_order; i++)
            begin
                window[i] <= '0;
            end
        end
        else
        begin
            window[0] <= in_sample;
            for (int i = 1; i < nabp_pkg::k_filter_order; i++)
            begin
                window[i] <= window[i-1];
            end
        end
    end

    // 2*x[k] - x[k-1] - x[k+1], operands sign extended to the sum width
    assign kernel_sum = (window[0] <<< 1) - window[1] - in_sample;

    // output register, one cycle of latency
    always_ff @(posedge clk)
    begin
        filtered_val <= nabp_pkg::filtered_t'(kernel_sum);
    end

    // registered value must match the full precision sum of the cycle before
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!reset_n)
        1'b1 |=> (filtered_val == $past(kernel_sum))
    );

endmodule

// File: source/filtered_ram_control.sv
module filtered_ram_control
(
    input  logic             clk,
    input  logic             reset_n,
    input  logic             fill_kick,
    output nabp_pkg::s_val_t hs_s_val,
    output logic             sample_valid,
    output logic             write_enable,
    output nabp_pkg::s_val_t write_addr,
    output logic             fill_done,
    output logic             fill_busy
);

    nabp_pkg::fill_state_t state;
    nabp_pkg::fill_state_t next_state;
    nabp_pkg::s_val_t read_idx;
    nabp_pkg::s_val_t write_idx;
    logic read_in_line;
    logic delay_done;

    // unsigned compare so the line end counts as 16 rather than -16
    assign read_in_line = ($unsigned(read_idx) < nabp_pkg::k_line_size);

    assign delay_done = (state == nabp_pkg::delay_s) &&
        (read_idx == nabp_pkg::s_val_t'(nabp_pkg::k_delay_cycles - 1));

    assign fill_done = (state == nabp_pkg::fill_s) &&
        (write_idx == nabp_pkg::s_val_t'(nabp_pkg::k_line_size - 1));

    assign fill_busy = (state != nabp_pkg::ready_s);
    assign write_enable = (state == nabp_pkg::fill_s);
    assign write_addr = write_idx;
    assign hs_s_val = read_idx;

    always_comb
    begin
        next_state = state;
        case (state)
            nabp_pkg::ready_s:
                if (fill_kick)
                    next_state = nabp_pkg::delay_s;
            nabp_pkg::delay_s:
                if (delay_done)
                    next_state = nabp_pkg::fill_s;
            nabp_pkg::fill_s:
                if (fill_done)
                    next_state = nabp_pkg::ready_s;
            default:
                next_state = nabp_pkg::ready_s;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= nabp_pkg::ready_s;
            read_idx <= '0;
            write_idx <= '0;
            sample_valid <= 1'b0;
        end
        else
        begin
            state <= next_state;
            // flag lines up with the sample the host returns next cycle
            sample_valid <= fill_busy && read_in_line;

            if (!fill_busy)
            begin
                read_idx <= '0;
                write_idx <= '0;
            end
            else
            begin
                // read index parks at the line end
                if (read_in_line)
                    read_idx <= read_idx + nabp_pkg::s_val_t'(1);
                if (fill_done)
                    write_idx <= '0;
                else if (state == nabp_pkg::fill_s)
                    write_idx <= write_idx + nabp_pkg::s_val_t'(1);
            end
        end
    end

    a_write_in_line: assert property (
        @(posedge clk) disable iff (!reset_n)
        write_enable |-> ($unsigned(write_addr) < nabp_pkg::k_line_size)
    );

    // done lands a full line after the last delay cycle
    a_done_in_fill: assert property (
        @(posedge clk) disable iff (!reset_n)
        fill_done |-> (state == nabp_pkg::fill_s) &&
            ($past(state, nabp_pkg::k_line_size) == nabp_pkg::delay_s)
    );

    // a kick mid-fill neither restarts nor stalls the walk
    a_kick_ignored: assert property (
        @(posedge clk) disable iff (!reset_n)
        (fill_kick && fill_busy && !delay_done && !fill_done) |=> $stable(state)
    );

endmodule

// File: source/filtered_ram.sv
module filtered_ram
(
    input  logic                clk,
    input  logic                write_enable,
    input  nabp_pkg::s_val_t    write_addr,
    input  nabp_pkg::filtered_t filtered_val,
    input  nabp_pkg::s_val_t    pr0_s_val,
    input  nabp_pkg::s_val_t    pr1_s_val,
    output nabp_pkg::filtered_t pr0_val,
    output nabp_pkg::filtered_t pr1_val
);

    // one filtered projection line
    nabp_pkg::filtered_t mem [nabp_pkg::k_line_size];

    always_ff @(posedge clk)
    begin
        if (write_enable)
        begin
            mem[write_addr[nabp_pkg::k_addr_length-1:0]] <= filtered_val;
        end
    end

    // both processing units read combinationally
    assign pr0_val = mem[pr0_s_val[nabp_pkg::k_addr_length-1:0]];
    assign pr1_val = mem[pr1_s_val[nabp_pkg::k_addr_length-1:0]];

    // the spare index bit would otherwise alias into the line
    a_read_in_line: assert property (
        @(posedge clk)
        !$isunknown({pr0_s_val, pr1_s_val}) |->
            ($unsigned(pr0_s_val) < nabp_pkg::k_line_size) &&
            ($unsigned(pr1_s_val) < nabp_pkg::k_line_size)
    );

endmodule

// File: source/filtered_line_buffer.sv
module filtered_line_buffer
(
    input  logic                clk,
    input  logic                reset_n,
    // host side
    input  logic                fill_kick,
    input  nabp_pkg::data_t     hs_val,
    output nabp_pkg::s_val_t    hs_s_val,
    output logic                fill_done,
    output logic                fill_busy,
    // processing unit read ports
    input  nabp_pkg::s_val_t    pr0_s_val,
    input  nabp_pkg::s_val_t    pr1_s_val,
    output nabp_pkg::filtered_t pr0_val,
    output nabp_pkg::filtered_t pr1_val
);

    logic sample_valid;
    logic write_enable;
    nabp_pkg::s_val_t write_addr;
    nabp_pkg::filtered_t filtered_val;

    filtered_ram_control control0
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .fill_kick    (fill_kick),
        .hs_s_val     (hs_s_val),
        .sample_valid (sample_valid),
        .write_enable (write_enable),
        .write_addr   (write_addr),
        .fill_done    (fill_done),
        .fill_busy    (fill_busy)
    );

    // raw samples from the host go straight into the kernel
    ramp_filter filter0
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .hs_val       (hs_val),
        .sample_valid (sample_valid),
        .filtered_val (filtered_val)
    );

    filtered_ram ram0
    (
        .clk          (clk),
        .write_enable (write_enable),
        .write_addr   (write_addr),
        .filtered_val (filtered_val),
        .pr0_s_val    (pr0_s_val),
        .pr1_s_val    (pr1_s_val),
        .pr0_val      (pr0_val),
        .pr1_val      (pr1_val)
    );

endmodule

// File: verif/filtered_line_buffer_tb.sv
module filtered_line_buffer_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int seed = 12;
    localparam int num_lines = 4;
    localparam int reset_cycles = 16;
    localparam int cycles_per_line = 40;
    // slack for the idle cycles around the fills
    localparam int cycle_limit = num_lines * cycles_per_line + reset_cycles + 24;
    localparam int done_latency = nabp_pkg::k_delay_cycles + nabp_pkg::k_line_size;
    localparam int a_msb = nabp_pkg::k_addr_length - 1;

    logic clk = 1'b0;
    logic reset_n;
    logic fill_kick;
    nabp_pkg::data_t hs_val = '0;
    nabp_pkg::s_val_t hs_s_val;
    logic fill_done;
    logic fill_busy;
    nabp_pkg::s_val_t pr0_s_val;
    nabp_pkg::s_val_t pr1_s_val;
    nabp_pkg::filtered_t pr0_val;
    nabp_pkg::filtered_t pr1_val;

    // host line and the ramp values it should produce
    nabp_pkg::data_t line_samples [nabp_pkg::k_line_size];
    nabp_pkg::filtered_t expect_line [nabp_pkg::k_line_size];
    nabp_pkg::filtered_t pr0_expect;
    nabp_pkg::filtered_t pr1_expect;
    int index_expect;

    logic [31:0] rng_state = seed;
    logic read_check;
    logic kick_pending = 1'b0;
    int kick_cycle = 0;
    int cycle_count = 0;
    int done_count = 0;
    int error_count = 0;

    filtered_line_buffer dut0
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .fill_kick (fill_kick),
        .hs_val    (hs_val),
        .hs_s_val  (hs_s_val),
        .fill_done (fill_done),
        .fill_busy (fill_busy),
        .pr0_s_val (pr0_s_val),
        .pr1_s_val (pr1_s_val),
        .pr0_val   (pr0_val),
        .pr1_val   (pr1_val)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
    end

    // host returns the requested sample one cycle later, junk past the line end
    always @(posedge clk)
    begin
        if (int'($unsigned(hs_s_val)) < nabp_pkg::k_line_size)
            hs_val <= line_samples[hs_s_val[a_msb:0]];
        else
            hs_val <= 12'h5a5;
    end

    // remember when a fill was accepted
    always @(posedge clk)
    begin
        if (reset_n && fill_kick && !fill_busy)
        begin
            kick_pending <= 1'b1;
            kick_cycle <= cycle_count;
        end
        if (reset_n && fill_done)
        begin
            kick_pending <= 1'b0;
            done_count <= done_count + 1;
        end
    end

    assign pr0_expect = expect_line[pr0_s_val[a_msb:0]];
    assign pr1_expect = expect_line[pr1_s_val[a_msb:0]];

    // read index runs from zero in the cycle after the kick and parks at the line end
    assign index_expect = (cycle_count - kick_cycle > nabp_pkg::k_line_size) ?
        nabp_pkg::k_line_size : cycle_count - kick_cycle - 1;

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // new random line, ramp rule with zero padding at both ends
    task automatic load_line();
        nabp_pkg::data_t samples [nabp_pkg::k_line_size];
        int left;
        int right;
        for (int i = 0; i < nabp_pkg::k_line_size; i++)
        begin
            rng_state = xorshift32(rng_state);
            samples[i] = nabp_pkg::data_t'(rng_state[nabp_pkg::k_data_length-1:0]);
        end
        for (int k = 0; k < nabp_pkg::k_line_size; k++)
        begin
            left = (k > 0) ? int'(samples[k-1]) : 0;
            right = (k < nabp_pkg::k_line_size - 1) ? int'(samples[k+1]) : 0;
            line_samples[k] <= samples[k];
            expect_line[k] <= nabp_pkg::filtered_t'(2 * int'(samples[k]) - left - right);
        end
    endtask

    task automatic wait_fill_done();
        do
            @(posedge clk);
        while (!fill_done);
    endtask

    // both ports walk the line in opposite directions
    task automatic sweep_read_ports();
        for (int i = 0; i < nabp_pkg::k_line_size; i++)
        begin
            pr0_s_val <= nabp_pkg::s_val_t'(i);
            pr1_s_val <= nabp_pkg::s_val_t'(nabp_pkg::k_line_size - 1 - i);
            read_check <= 1'b1;
            @(posedge clk);
        end
        read_check <= 1'b0;
    endtask

    task automatic print_totals();
        $display("closing report: %0d fills completed, %0d errors", done_count, error_count);
    endtask

    a_reset_done: assert property (
        @(posedge clk) (cycle_count >= 1 && cycle_count <= reset_cycles + 1) |-> !fill_done
    ) else begin
        error_count = error_count + 1;
        $display("FAIL fill_done in reset: expected 0x0, got 0x%h", $sampled(fill_done));
    end

    a_reset_busy: assert property (
        @(posedge clk) (cycle_count >= 1 && cycle_count <= reset_cycles + 1) |-> !fill_busy
    ) else begin
        error_count = error_count + 1;
        $display("FAIL fill_busy in reset: expected 0x0, got 0x%h", $sampled(fill_busy));
    end

    a_index_walk: assert property (
        @(posedge clk) disable iff (!reset_n)
        kick_pending |-> (int'($unsigned(hs_s_val)) == index_expect)
    ) else begin
        error_count = error_count + 1;
        $display("FAIL hs_s_val: expected 0x%h, got 0x%h", $sampled(index_expect),
            $sampled(hs_s_val));
    end

    a_done_latency: assert property (
        @(posedge clk) disable iff (!reset_n)
        (fill_done && kick_pending) |-> (cycle_count - kick_cycle == done_latency)
    ) else begin
        error_count = error_count + 1;
        $display("FAIL fill_done latency: expected 0x%h, got 0x%h", done_latency,
            $sampled(cycle_count) - $sampled(kick_cycle));
    end

    a_done_once: assert property (
        @(posedge clk) disable iff (!reset_n)
        fill_done |-> kick_pending
    ) else begin
        error_count = error_count + 1;
        $display("fill_done pulsed while no accepted fill was pending");
    end

    a_done_missing: assert property (
        @(posedge clk) disable iff (!reset_n)
        kick_pending |-> (cycle_count - kick_cycle <= done_latency)
    ) else begin
        error_count = error_count + 1;
        $display("fill_done did not arrive in time after an accepted kick");
    end

    a_busy_high: assert property (
        @(posedge clk) disable iff (!reset_n)
        kick_pending |-> fill_busy
    ) else begin
        error_count = error_count + 1;
        $display("FAIL fill_busy during fill: expected 0x1, got 0x%h", $sampled(fill_busy));
    end

    a_busy_falls: assert property (
        @(posedge clk) disable iff (!reset_n)
        $past(fill_done) |-> !fill_busy
    ) else begin
        error_count = error_count + 1;
        $display("FAIL fill_busy after fill_done: expected 0x0, got 0x%h", $sampled(fill_busy));
    end

    a_pr0_value: assert property (
        @(posedge clk) disable iff (!reset_n)
        read_check |-> (pr0_val == pr0_expect)
    ) else begin
        error_count = error_count + 1;
        $display("FAIL pr0_val at index 0x%h: expected 0x%h, got 0x%h",
            $sampled(pr0_s_val), $sampled(pr0_expect), $sampled(pr0_val));
    end

    a_pr1_value: assert property (
        @(posedge clk) disable iff (!reset_n)
        read_check |-> (pr1_val == pr1_expect)
    ) else begin
        error_count = error_count + 1;
        $display("FAIL pr1_val at index 0x%h: expected 0x%h, got 0x%h",
            $sampled(pr1_s_val), $sampled(pr1_expect), $sampled(pr1_val));
    end

    initial
    begin
        reset_n <= 1'b0;
        fill_kick <= 1'b0;
        pr0_s_val <= '0;
        pr1_s_val <= '0;
        read_check <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        reset_n <= 1'b1;
        repeat (2) @(posedge clk);
        for (int line = 0; line < num_lines; line++)
        begin
            load_line();
            @(posedge clk);
            fill_kick <= 1'b1;
            @(posedge clk);
            fill_kick <= 1'b0;
            // first line also gets a stray kick in the middle of the fill
            if (line == 0)
            begin
                repeat (6) @(posedge clk);
                fill_kick <= 1'b1;
                @(posedge clk);
                fill_kick <= 1'b0;
            end
            wait_fill_done();
            sweep_read_ports();
        end
        repeat (2) @(posedge clk);
        if (done_count != num_lines)
        begin
            error_count = error_count + 1;
            $display("FAIL done_count: expected 0x%h, got 0x%h", num_lines, done_count);
        end
        print_totals();
        if (error_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    initial
    begin
        while (cycle_count < cycle_limit)
            @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        print_totals();
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: filtered_line_buffer.f
source/nabp_pkg.sv
source/ramp_filter.sv
source/filtered_ram_control.sv
source/filtered_ram.sv
source/filtered_line_buffer.sv
verif/filtered_line_buffer_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the filtered line buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module filtered_line_buffer_tb \
    -f filtered_line_buffer.f -Mdir obj_dir -o sim_top > build.log 2>&1 &&
    ./obj_dir/sim_top > sim.log 2>&1 ||
    { echo "build or run error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && { echo "result: FAIL"; exit 1; }
echo "result: PASS"
exit 0
